//--- sched_pkg.sv
package sched_pkg;

	// ==========================================================
	// ROB geometry
	// ==========================================================

	// Number of reorder buffer entries visible to the scheduler
	localparam int ROB_ENTRIES = 16;
	localparam int ROB_NDX_W = 4;
	// Sequence numbers follow program order, a smaller value is older
	localparam int SN_W = 6;

	typedef logic [ROB_NDX_W-1:0] rob_ndx_t;
	typedef logic [ROB_ENTRIES-1:0] rob_mask_t;

	// Operation class decides which execution units may accept an entry
	typedef enum logic [2:0] {
		OP_NOP  = 3'd0,
		OP_ALU  = 3'd1,
		OP_ALU0 = 3'd2,
		OP_MEM  = 3'd3,
		OP_FC   = 3'd4,
		OP_SYNC = 3'd5
	} op_class_e;

	// One ROB entry as the scheduler sees it
	// arg_v holds operand A in bit 2, B in bit 1 and C in bit 0
	typedef struct packed {
		logic valid;
		logic [SN_W-1:0] sn;
		logic done;
		logic out;
		logic [2:0] arg_v;
		op_class_e op;
	} rob_entry_t;

	// Entry 0 sits in the least significant bits
	typedef rob_entry_t [ROB_ENTRIES-1:0] rob_t;

	// ==========================================================
	// Execution unit side
	// ==========================================================

	// Idle flags, in unit order alu0, alu1, fcu, agen0, agen1
	typedef struct packed {
		logic alu0;
		logic alu1;
		logic fcu;
		logic agen0;
		logic agen1;
	} unit_idle_t;

	typedef struct packed {
		logic valid;
		rob_ndx_t ndx;
	} grant_t;

	// Same unit order as the idle flags
	typedef struct packed {
		grant_t alu0;
		grant_t alu1;
		grant_t fcu;
		grant_t agen0;
		grant_t agen1;
	} unit_grants_t;

endpackage

//--- sched_ready.sv
module sched_ready
	import sched_pkg::*;
#(
	parameter int WINDOW_SIZE = 8
) (
	input  logic clk,
	input  logic rst,
	input  rob_t rob_i,
	input  rob_ndx_t head_i,
	input  rob_mask_t issued_i,
	output rob_mask_t ready_o,
	output rob_ndx_t [WINDOW_SIZE-1:0] win_ndx_o
);

	// Operands A and B are present and C is present or not needed
	rob_mask_t args_ok;
	// An older sync entry is still in the ROB
	rob_mask_t prior_sync;
	// An older flow-control entry has not finished yet
	rob_mask_t prior_fc;
	rob_mask_t ready_d;
	rob_ndx_t [WINDOW_SIZE-1:0] win_ndx_d;

	// ==========================================================
	// Operand check
	// ==========================================================

	// Memory ops only need A and B for address generation
	// Operand C is the store data and is picked up later
	always_comb begin
		for (int e = 0; e < ROB_ENTRIES; e++) begin
			args_ok[e] = rob_i[e].arg_v[2] && rob_i[e].arg_v[1]
				&& (rob_i[e].arg_v[0] || rob_i[e].op == OP_MEM);
		end
	end

	// ==========================================================
	// Age scans
	// ==========================================================

	// Every entry is compared against every other entry by sequence number
	// The entry itself never matches because its sn is not smaller than itself
	// The cost grows as entries squared
	always_comb begin
		prior_sync = '0;
		prior_fc = '0;
		for (int e = 0; e < ROB_ENTRIES; e++) begin
			for (int o = 0; o < ROB_ENTRIES; o++) begin
				if (rob_i[o].valid && rob_i[o].sn < rob_i[e].sn) begin
					// A sync holds back younger work until it leaves the ROB
					if (rob_i[o].op == OP_SYNC)
						prior_sync[e] = 1'b1;
					// Flow control waits only while the older one is unfinished
					if (rob_i[o].op == OP_FC && !rob_i[o].done)
						prior_fc[e] = 1'b1;
				end
			end
		end
	end

	// Final readiness per entry
	// The issued mask keeps an entry granted last cycle out of this snapshot
	always_comb begin
		for (int e = 0; e < ROB_ENTRIES; e++) begin
			ready_d[e] = rob_i[e].valid && !rob_i[e].done && !rob_i[e].out
				&& args_ok[e]
				&& !prior_sync[e]
				&& !(rob_i[e].op == OP_FC && prior_fc[e])
				&& !issued_i[e];
		end
	end

	// Window positions start at the head and wrap through the 4-bit index
	always_comb begin
		for (int w = 0; w < WINDOW_SIZE; w++)
			win_ndx_d[w] = head_i + rob_ndx_t'(w);
	end

	// Registered so the picker works from a stable snapshot
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_o <= '0;
			win_ndx_o <= '0;
		end else begin
			ready_o <= ready_d;
			win_ndx_o <= win_ndx_d;
		end
	end

endmodule

//--- sched_picker.sv
module sched_picker
	import sched_pkg::*;
#(
	parameter int WINDOW_SIZE = 8
) (
	input  logic clk,
	input  logic rst,
	input  rob_t rob_i,
	input  rob_mask_t ready_i,
	input  rob_ndx_t [WINDOW_SIZE-1:0] win_ndx_i,
	input  unit_idle_t idle_i,
	output unit_grants_t grants_o,
	output rob_mask_t issue_o
);

	// Grants being built for the next edge
	// A grant's valid bit doubles as the unit taken flag during the walk
	unit_grants_t grants_d;
	rob_mask_t issue_d;
	// Entry at the window position under consideration
	rob_ndx_t cand;
	// Entries that may take part in this cycle's selection
	rob_mask_t eligible;

	// ==========================================================
	// Eligibility
	// ==========================================================

	// The ready stage sees the grant mask one cycle late
	// Masking with our own registered grants here keeps an entry
	// from being handed out on two consecutive edges
	assign eligible = ready_i & ~issue_o;

	// ==========================================================
	// Window walk
	// ==========================================================

	// Position 0 is the ROB head and therefore the oldest candidate
	// Earlier positions claim units first, giving first-come selection
	always_comb begin
		grants_d = '0;
		issue_d = '0;
		cand = '0;
		for (int w = 0; w < WINDOW_SIZE; w++) begin
			cand = win_ndx_i[w];
			if (eligible[cand]) begin
				case (rob_i[cand].op)
					// General ALU work and sync barriers run on either ALU
					// ALU0 is tried first and ALU1 picks up the overflow
					OP_ALU, OP_SYNC: begin
						if (idle_i.alu0 && !grants_d.alu0.valid) begin
							grants_d.alu0.valid = 1'b1;
							grants_d.alu0.ndx = cand;
							issue_d[cand] = 1'b1;
						end else if (idle_i.alu1 && !grants_d.alu1.valid) begin
							grants_d.alu1.valid = 1'b1;
							grants_d.alu1.ndx = cand;
							issue_d[cand] = 1'b1;
						end
					end
					// Some ALU ops exist only on ALU0 and wait while it is busy
					OP_ALU0: begin
						if (idle_i.alu0 && !grants_d.alu0.valid) begin
							grants_d.alu0.valid = 1'b1;
							grants_d.alu0.ndx = cand;
							issue_d[cand] = 1'b1;
						end
					end
					// Loads and stores go to the first free address generator
					OP_MEM: begin
						if (idle_i.agen0 && !grants_d.agen0.valid) begin
							grants_d.agen0.valid = 1'b1;
							grants_d.agen0.ndx = cand;
							issue_d[cand] = 1'b1;
						end else if (idle_i.agen1 && !grants_d.agen1.valid) begin
							grants_d.agen1.valid = 1'b1;
							grants_d.agen1.ndx = cand;
							issue_d[cand] = 1'b1;
						end
					end
					// There is only one flow-control unit and the ready stage
					// already enforced program order between branches
					OP_FC: begin
						if (idle_i.fcu && !grants_d.fcu.valid) begin
							grants_d.fcu.valid = 1'b1;
							grants_d.fcu.ndx = cand;
							issue_d[cand] = 1'b1;
						end
					end
					// NOP entries never occupy a unit
					default: ;
				endcase
			end
		end
	end

	// ==========================================================
	// Grant registers
	// ==========================================================

	// Each grant is a single cycle pulse to its unit
	// There is no back-pressure and a busy unit simply is not granted
	always_ff @(posedge clk) begin
		if (rst) begin
			grants_o <= '0;
			issue_o <= '0;
		end else begin
			grants_o <= grants_d;
			issue_o <= issue_d;
		end
	end

endmodule

//--- sched_top.sv
module sched_top
	import sched_pkg::*;
#(
	parameter int WINDOW_SIZE = 8
) (
	input  logic clk,
	input  logic rst,
	input  rob_t rob_i,
	input  rob_ndx_t head_i,
	input  unit_idle_t idle_i,
	output unit_grants_t grants_o,
	output rob_mask_t issue_o
);

	// Registered readiness and window positions from the first stage
	rob_mask_t ready;
	rob_ndx_t [WINDOW_SIZE-1:0] win_ndx;

	// ==========================================================
	// Readiness stage
	// ==========================================================

	// The grant mask loops back so a just-issued entry drops out
	sched_ready #(
		.WINDOW_SIZE(WINDOW_SIZE)
	) i_sched_ready (
		.clk       (clk),
		.rst       (rst),
		.rob_i     (rob_i),
		.head_i    (head_i),
		.issued_i  (issue_o),
		.ready_o   (ready),
		.win_ndx_o (win_ndx)
	);

	// ==========================================================
	// Unit selection stage
	// ==========================================================

	sched_picker #(
		.WINDOW_SIZE(WINDOW_SIZE)
	) i_sched_picker (
		.clk       (clk),
		.rst       (rst),
		.rob_i     (rob_i),
		.ready_i   (ready),
		.win_ndx_i (win_ndx),
		.idle_i    (idle_i),
		.grants_o  (grants_o),
		.issue_o   (issue_o)
	);

endmodule

//--- tb_sched.sv
module tb_sched
	import sched_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Pipeline needs three quiet cycles before a pattern is applied
	localparam int DRAIN_MIN = 3;
	localparam int DRAIN_LIMIT = 20;
	localparam int MAX_LINES = 200;
	// Name, head, idle, sixteen entry words and five valid/index pairs
	localparam int FIELDS = 29;

	logic clk;
	logic rst;
	rob_t rob;
	rob_ndx_t head;
	unit_idle_t idle;
	unit_grants_t grants;
	rob_mask_t issue;

	int err_cnt;
	int pass_cnt;
	int fail_cnt;
	int pat_cnt;
	// Set when a wait ran out, no further patterns are applied then
	bit aborted;

	sched_top #(
		.WINDOW_SIZE(8)
	) i_sched_top (
		.clk      (clk),
		.rst      (rst),
		.rob_i    (rob),
		.head_i   (head),
		.idle_i   (idle),
		.grants_o (grants),
		.issue_o  (issue)
	);

	always #4 clk = ~clk;

	// ==========================================================
	// Helpers
	// ==========================================================

	task automatic check_value(input string test, input string what,
		input logic [31:0] exp_val, input logic [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("Fail %s %s: expected %h, actual %h", test, what, exp_val, act_val);
			err_cnt++;
		end
	endtask

	// Valid bits only, in unit order alu0 down to agen1
	function automatic logic [4:0] grant_valid_bits(unit_grants_t g);
		return {g.alu0.valid, g.alu1.valid, g.fcu.valid, g.agen0.valid, g.agen1.valid};
	endfunction

	// Every valid grant marks its ROB entry as issued
	function automatic rob_mask_t issue_of(unit_grants_t g);
		grant_t list [5];
		rob_mask_t m;
		list = '{g.alu0, g.alu1, g.fcu, g.agen0, g.agen1};
		m = '0;
		for (int u = 0; u < 5; u++) begin
			if (list[u].valid)
				m[list[u].ndx] = 1'b1;
		end
		return m;
	endfunction

	task automatic wait_edges(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
	endtask

	// Empty ROB until nothing is in flight, bounded by DRAIN_LIMIT cycles
	task automatic drain_pipeline(output bit ok);
		ok = 1'b0;
		@(posedge clk);
		rob <= '0;
		head <= '0;
		idle <= '0;
		for (int cyc = 1; cyc <= DRAIN_LIMIT; cyc++) begin
			@(negedge clk);
			if (cyc >= DRAIN_MIN && issue == '0 && grant_valid_bits(grants) == '0) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	task automatic report_test(input string test, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("Test %s passed", test);
			pass_cnt++;
		end else begin
			$display("Test %s failed", test);
			fail_cnt++;
		end
	endtask

	// ==========================================================
	// Test sequences
	// ==========================================================

	// Reset is seen on two edges, the third edge is the first free cycle
	task automatic check_reset();
		int errs_before;
		errs_before = err_cnt;
		for (int cyc = 0; cyc < 3; cyc++) begin
			@(posedge clk);
			if (cyc == 1)
				rst <= 1'b0;
			@(negedge clk);
			check_value("reset", "grant valid", '0, grant_valid_bits(grants));
			check_value("reset", "issue_o", '0, issue);
		end
		report_test("reset", errs_before);
	endtask

	task automatic run_pattern(input string test, input rob_t p_rob, input rob_ndx_t p_head,
		input unit_idle_t p_idle, input unit_grants_t exp_g);
		int errs_before;
		bit drained;
		rob_mask_t exp_issue;
		rob_mask_t first_issue;
		errs_before = err_cnt;
		exp_issue = issue_of(exp_g);
		drain_pipeline(drained);
		if (!drained) begin
			$display("Timeout: outputs did not go quiet before test %s", test);
			err_cnt++;
			aborted = 1'b1;
		end else begin
			@(posedge clk);
			rob <= p_rob;
			head <= p_head;
			idle <= p_idle;
			// One edge for readiness, one for the grant registers
			wait_edges(2);
			@(negedge clk);
			check_value(test, "grants_o", exp_g, grants);
			check_value(test, "issue_o", exp_issue, issue);
			first_issue = issue;
			// With inputs held, no entry may be granted on two edges in a row
			@(negedge clk);
			check_value(test, "regrant", '0, issue & first_issue);
		end
		report_test(test, errs_before);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		int fd;
		int rc;
		int line_no;
		string text;
		string tname;
		logic [7:0] head_w;
		logic [7:0] idle_w;
		logic [15:0] ent_w [ROB_ENTRIES];
		logic [3:0] gv [5];
		logic [3:0] gn [5];
		rob_t p_rob;
		unit_grants_t exp_g;

		clk = 1'b0;
		rst = 1'b1;
		rob = '0;
		head = '0;
		idle = '0;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		pat_cnt = 0;
		aborted = 1'b0;

		check_reset();

		fd = $fopen("sched_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file sched_patterns.txt");
			fail_cnt++;
		end else begin
			line_no = 0;
			while (!aborted && !$feof(fd) && line_no < MAX_LINES) begin
				text = "";
				rc = $fgets(text, fd);
				line_no++;
				// Blank lines and column notes carry no pattern
				if (rc == 0 || text.len() < 2 || text.getc(0) == "#")
					continue;
				rc = $sscanf(text, "%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
					tname, head_w, idle_w,
					ent_w[0], ent_w[1], ent_w[2], ent_w[3], ent_w[4], ent_w[5], ent_w[6], ent_w[7],
					ent_w[8], ent_w[9], ent_w[10], ent_w[11], ent_w[12], ent_w[13], ent_w[14],
					ent_w[15], gv[0], gn[0], gv[1], gn[1], gv[2], gn[2], gv[3], gn[3], gv[4], gn[4]);
				if (rc != FIELDS) begin
					$display("Pattern line %0d is malformed, read %0d of %0d fields",
						line_no, rc, FIELDS);
					fail_cnt++;
					continue;
				end
				for (int e = 0; e < ROB_ENTRIES; e++)
					p_rob[e] = rob_entry_t'(ent_w[e][14:0]);
				// Packed order is alu0 first, each as valid then index
				exp_g = {gv[0][0], gn[0], gv[1][0], gn[1], gv[2][0], gn[2],
					gv[3][0], gn[3], gv[4][0], gn[4]};
				pat_cnt++;
				run_pattern(tname, p_rob, rob_ndx_t'(head_w), unit_idle_t'(idle_w[4:0]), exp_g);
			end
			$fclose(fd);
		end

		if (pat_cnt == 0) begin
			$display("No test patterns were read from sched_patterns.txt");
			fail_cnt++;
		end

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- sched_patterns.txt
# name head idle entry0..entry15, then alu0 alu1 fcu agen0 agen1 as valid/index pairs
# entry word from bit 14 down: valid, sn(6), done, out, arg_v A B C, op(3)
alu_order 2 1F 0000 0000 0000 4339 0000 4539 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 3 1 5 0 0 0 0 0 0
alu0_first 0 1F 0000 413A 4239 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 1 2 0 0 0 0 0 0
alu0_busy 0 0F 0000 413A 4239 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 1 2 0 0 0 0 0 0
alu_before_alu0 0 1F 0000 4139 423A 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
alu_third 0 1F 4039 4139 4239 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 0 1 1 0 0 0 0 0 0
alu_none_idle 0 07 4039 413B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 1 1 0 0
miss_a 0 1F 4019 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
miss_b 0 1F 4029 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
done_entry 0 1F 40B9 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
out_entry 0 1F 4079 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
nop_entry 0 1F 4038 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
filter_all 0 1F 4019 4129 42B9 4379 4438 451B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
alu_no_c 0 1F 4031 4133 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 1 1 0 0
mem_no_c 0 1F 4033 413B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 1 0 1 1
agen0_busy 0 1D 403B 413B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 1 0
sync_block 0 1F 403D 4139 423B 433C 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 0 0 0 0 0 0 0 0 0
sync_not_ready 0 1F 401D 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
sync_done 0 1F 40BD 4139 423B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
sync_younger 0 1F 4039 413D 423B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 0 1 1 0 0 0 0 0 0
sync_sn_order 0 1F 4539 423D 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
sync_invalid 0 1F 003D 4139 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 0 0 0 0
fc_order 0 1F 403C 413C 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 1 0 0 0 0 0
fc_older_done 0 1F 40BC 413C 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 1 1 0 0 0 0
fc_older_waiting 0 1F 401C 413C 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
fc_sn_order 0 1F 443C 413C 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 1 1 0 0 0 0
fc_busy 0 1B 403C 4139 423B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 1 0 0 0 0 1 2 0 0
wrap 0C 1F 443B 4539 463B 473C 0000 0000 0000 0000 0000 0000 0000 0000 403C 4139 423B 4339 1 D 1 F 1 C 1 E 1 0
wrap_full 0C 1F 0000 0000 0000 0000 0000 4939 0000 0000 0000 0000 0000 0000 4039 4139 0000 0000 1 C 1 D 0 0 0 0 0 0
wrap_only5 0C 1F 0000 0000 0000 0000 0000 4539 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
wrap_order 0F 1F 4039 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 423A 1 F 1 0 0 0 0 0 0 0
win_edge 1 1F 0000 0000 0000 0000 0000 0000 0000 0000 4839 0000 0000 0000 0000 0000 0000 0000 1 8 0 0 0 0 0 0 0 0
win_past 0 1F 0000 0000 0000 0000 0000 0000 0000 0000 4839 0000 0000 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0
all_units 0 1F 403A 4139 423C 433B 443B 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1 0 1 1 1 2 1 3 1 4

//--- tb.f
sched_pkg.sv
sched_ready.sv
sched_picker.sv
sched_top.sv
tb_sched.sv

//--- Bender.yml
package:
  name: sched

sources:
  - sched_pkg.sv
  - sched_ready.sv
  - sched_picker.sv
  - sched_top.sv
  - target: test
    files:
      - tb_sched.sv
